// File: common/vscale_pkg.sv
package vscale_pkg;

    // one source row in 12-bit-fraction fixed point
    localparam int ROW_ONE = 4096;

    // weight magnitude width, 512 is unity gain
    localparam int COE_WIDTH = 10;

    // row position, 12 integer bits and 12 fraction bits
    localparam int POS_WIDTH = 24;

    // width of each half of the position word
    localparam int ROW_BITS = POS_WIDTH / 2;

    // position word, stepped as one number, split into row and phase for use
    typedef union packed {
        logic [POS_WIDTH-1:0] raw;
        struct packed {
            // integer source row index
            logic [ROW_BITS-1:0] row;
            // phase between row and row+1
            logic [ROW_BITS-1:0] frac;
        } fields;
    } row_pos_u;

    // first output row sits two rows in, so taps m-2 and m-1 exist
    localparam row_pos_u POS_START = row_pos_u'(POS_WIDTH'(2 * ROW_ONE));

    // sequencer FSM
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        EMIT
    } seq_state_e;

endpackage

// File: common/row_tap_if.sv
`timescale 1ns/1ps

interface row_tap_if #(
    parameter int DATA_WIDTH = 8
);
    // tap0 is the oldest row, tap3 the newest
    logic [DATA_WIDTH-1:0] tap0;
    logic [DATA_WIDTH-1:0] tap1;
    logic [DATA_WIDTH-1:0] tap2;
    logic [DATA_WIDTH-1:0] tap3;

    // one pulse per output pixel
    logic valid;
    // pixel opens an output row
    logic first_pix;
    // pixel belongs to output row 0 of the frame
    logic first_row;

    modport src (output tap0, tap1, tap2, tap3, valid, first_pix, first_row);

    modport dst (input tap0, tap1, tap2, tap3, valid, first_pix, first_row);

endinterface

// File: row_store/row_ram.sv
`timescale 1ns/1ps

module row_ram #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 1024,
    localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [DATA_WIDTH-1:0] wr_data_i,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i,
    output logic [DATA_WIDTH-1:0] rd_data_o
);
    // one source row, block memory
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_data_o <= '0;
        end else begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// File: row_store/row_store.sv
`timescale 1ns/1ps

module row_store #(
    parameter int DATA_WIDTH = 8,
    parameter int ROW_LEN_MAX = 1024,
    localparam int ADDR_WIDTH = $clog2(ROW_LEN_MAX),
    localparam int ROW_BITS = vscale_pkg::ROW_BITS
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [DATA_WIDTH-1:0] di_i,
    input  logic                  de_i,
    input  logic                  vs_i,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i,
    input  logic                  rd_strobe_i,
    input  logic                  first_pix_i,
    input  logic                  first_row_i,
    input  logic [ROW_BITS-1:0]   newest_row_i,
    output logic [ROW_BITS-1:0]   rows_done_o,
    row_tap_if.src                taps
);
    localparam int SLOTS = 5;

    // registered source
    logic [DATA_WIDTH-1:0] di_q;
    logic                  de_q;
    logic                  vs_q;

    logic de_fall;
    logic vs_fall;
    logic frame_active;
    logic wr_en;

    // write side
    logic [2:0]            wr_slot;
    logic [ADDR_WIDTH-1:0] wr_addr;

    // read side
    logic [DATA_WIDTH-1:0] rd_data [SLOTS];
    logic [DATA_WIDTH-1:0] tap_sel [4];
    logic [2:0]            slot_new;
    logic [2:0]            slot_q;
    logic                  strobe_q;
    logic                  first_pix_q;
    logic                  first_row_q;

    // last pixel of the row is still in de_q
    assign de_fall = de_q & ~de_i;
    assign vs_fall = vs_q & ~vs_i;
    assign wr_en   = frame_active & de_q & ~vs_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_q <= 1'b0;
            vs_q <= 1'b0;
        end else begin
            de_q <= de_i;
            vs_q <= vs_i;
        end
    end

    always_ff @(posedge clk) begin
        di_q <= di_i;
    end

    // round-robin slot, row n lands in slot n mod 5
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            frame_active <= 1'b0;
            wr_slot      <= '0;
            wr_addr      <= '0;
            rows_done_o  <= '0;
        end else if (vs_q) begin
            // frame held in reset, opens on the vs falling edge
            frame_active <= vs_fall;
            wr_slot      <= '0;
            wr_addr      <= '0;
            rows_done_o  <= '0;
        end else if (frame_active) begin
            if (de_fall) begin
                wr_addr     <= '0;
                wr_slot     <= (wr_slot == 3'(SLOTS - 1)) ? 3'd0 : wr_slot + 3'd1;
                rows_done_o <= rows_done_o + 1'b1;
            end else if (de_q) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    for (genvar g = 0; g < SLOTS; g++) begin : g_slot
        row_ram #(
            .DATA_WIDTH (DATA_WIDTH),
            .DEPTH      (ROW_LEN_MAX)
        ) row_ram0 (
            .clk       (clk),
            .arst_n_i  (arst_n_i),
            .we_i      (wr_en && (wr_slot == 3'(g))),
            .wr_addr_i (wr_addr),
            .wr_data_i (di_q),
            .rd_addr_i (rd_addr_i),
            .rd_data_o (rd_data[g])
        );
    end

    assign slot_new = 3'(newest_row_i % SLOTS);

    // tap k is 3-k rows behind tap3
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            tap_sel[k] = rd_data[(32'(slot_q) + 2 + k) % SLOTS];
        end
    end

    // stage 1 matches the RAM read, stage 2 the rotate
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_q          <= '0;
            strobe_q        <= 1'b0;
            first_pix_q     <= 1'b0;
            first_row_q     <= 1'b0;
            taps.valid      <= 1'b0;
            taps.first_pix  <= 1'b0;
            taps.first_row  <= 1'b0;
        end else begin
            slot_q          <= slot_new;
            strobe_q        <= rd_strobe_i;
            first_pix_q     <= first_pix_i;
            first_row_q     <= first_row_i;
            taps.valid      <= strobe_q;
            taps.first_pix  <= first_pix_q;
            taps.first_row  <= first_row_q;
        end
    end

    always_ff @(posedge clk) begin
        taps.tap0 <= tap_sel[0];
        taps.tap1 <= tap_sel[1];
        taps.tap2 <= tap_sel[2];
        taps.tap3 <= tap_sel[3];
    end

endmodule

// File: logic/row_sequencer.sv
`timescale 1ns/1ps

module row_sequencer #(
    parameter int ROW_LEN_MAX = 1024,
    parameter int TABLE_BITS = 10,
    parameter int SPARSE_GAP = 2,
    localparam int ADDR_WIDTH = $clog2(ROW_LEN_MAX),
    localparam int ROW_BITS = vscale_pkg::ROW_BITS,
    localparam int GAP_WIDTH = (SPARSE_GAP > 0) ? $clog2(SPARSE_GAP + 1) : 1
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  vs_i,
    input  logic [15:0]           scale_step_i,
    input  logic [ADDR_WIDTH-1:0] row_len_i,
    input  logic [ROW_BITS-1:0]   rows_done_i,
    output logic [ADDR_WIDTH-1:0] rd_addr_o,
    output logic                  rd_strobe_o,
    output logic                  first_pix_o,
    output logic                  first_row_o,
    output logic [ROW_BITS-1:0]   newest_row_o,
    output logic [TABLE_BITS-1:0] phase_o
);
    vscale_pkg::row_pos_u   pos_q;
    vscale_pkg::seq_state_e state_q;

    logic [GAP_WIDTH-1:0]  gap_q;
    logic [ADDR_WIDTH-1:0] pix_q;
    // still on output row 0
    logic                  row0_q;
    logic                  row_ready;

    // taps m-2 .. m+1 are all stored once rows_done passes m+1
    assign row_ready = {1'b0, rows_done_i} > ({1'b0, pos_q.fields.row} + 1'b1);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= vscale_pkg::IDLE;
            pos_q        <= vscale_pkg::POS_START;
            gap_q        <= '0;
            pix_q        <= '0;
            row0_q       <= 1'b1;
            rd_addr_o    <= '0;
            rd_strobe_o  <= 1'b0;
            first_pix_o  <= 1'b0;
            first_row_o  <= 1'b0;
            newest_row_o <= '0;
            phase_o      <= '0;
        end else begin
            rd_strobe_o <= 1'b0;
            if (vs_i) begin
                state_q <= vscale_pkg::IDLE;
                pos_q   <= vscale_pkg::POS_START;
                gap_q   <= '0;
                pix_q   <= '0;
                row0_q  <= 1'b1;
            end else begin
                case (state_q)
                    vscale_pkg::IDLE: begin
                        if (row_ready) begin
                            // tap slot held until the next row starts
                            newest_row_o <= pos_q.fields.row + 1'b1;
                            state_q      <= vscale_pkg::SETUP;
                        end
                    end
                    vscale_pkg::SETUP: begin
                        // last pixel of the previous row is past the multiply by now
                        // phase held until the next setup, coe table settles here
                        phase_o <= pos_q.fields.frac[ROW_BITS-1 -: TABLE_BITS];
                        gap_q   <= '0;
                        pix_q   <= '0;
                        state_q <= vscale_pkg::EMIT;
                    end
                    vscale_pkg::EMIT: begin
                        if (gap_q == '0) begin
                            rd_strobe_o <= 1'b1;
                            rd_addr_o   <= pix_q;
                            first_pix_o <= (pix_q == '0);
                            first_row_o <= row0_q;
                            gap_q       <= GAP_WIDTH'(SPARSE_GAP);
                            pix_q       <= pix_q + 1'b1;
                            if (pix_q == row_len_i) begin
                                // last pixel, step to the next output row
                                pos_q.raw <= pos_q.raw + vscale_pkg::POS_WIDTH'(scale_step_i);
                                row0_q    <= 1'b0;
                                state_q   <= vscale_pkg::IDLE;
                            end
                        end else begin
                            gap_q <= gap_q - 1'b1;
                        end
                    end
                    default: begin
                        state_q <= vscale_pkg::IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// File: logic/coe_rom.sv
`timescale 1ns/1ps

module coe_rom #(
    parameter int TABLE_BITS = 10,
    localparam int DEPTH = 2 ** TABLE_BITS,
    localparam int CW = vscale_pkg::COE_WIDTH
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [TABLE_BITS-1:0] phase_i,
    output logic [CW-1:0]         w0_o,
    output logic [CW-1:0]         w1_o,
    output logic [CW-1:0]         w2_o,
    output logic [CW-1:0]         w3_o
);
    // catmull-rom weight magnitude for t = x/DEPTH, round to nearest on 512
    function automatic logic [CW-1:0] cubic_weight(input int tap, input int x);
        longint n;
        longint xl;
        longint num;
        n  = longint'(DEPTH);
        xl = longint'(x);
        // numerators scaled by n^3, all non-negative for 0 <= t < 1
        case (tap)
            0:       num = xl * xl * xl - 2 * xl * xl * n + xl * n * n;
            1:       num = 3 * xl * xl * xl - 5 * xl * xl * n + 2 * n * n * n;
            2:       num = -3 * xl * xl * xl + 4 * xl * xl * n + xl * n * n;
            default: num = xl * xl * n - xl * xl * xl;
        endcase
        // 512 scale times the 1/2 of the kernel
        return CW'((num * 256 + (n * n * n) / 2) / (n * n * n));
    endfunction

    // w3 .. w0 packed per phase
    logic [4*CW-1:0] rom [DEPTH];

    for (genvar g = 0; g < DEPTH; g++) begin : g_entry
        assign rom[g] = {cubic_weight(3, g), cubic_weight(2, g),
                         cubic_weight(1, g), cubic_weight(0, g)};
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            {w3_o, w2_o, w1_o, w0_o} <= '0;
        end else begin
            {w3_o, w2_o, w1_o, w0_o} <= rom[phase_i];
        end
    end

endmodule

// File: logic/tap_filter.sv
`timescale 1ns/1ps

module tap_filter #(
    parameter int DATA_WIDTH = 8,
    localparam int CW = vscale_pkg::COE_WIDTH,
    localparam int MUL_WIDTH = CW + DATA_WIDTH,
    localparam int SUM_WIDTH = MUL_WIDTH + 2,
    // 512 is unity
    localparam int SHIFT = CW - 1
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [CW-1:0]         w0_i,
    input  logic [CW-1:0]         w1_i,
    input  logic [CW-1:0]         w2_i,
    input  logic [CW-1:0]         w3_i,
    row_tap_if.dst                taps,
    output logic [DATA_WIDTH-1:0] do_o,
    output logic                  de_o,
    output logic                  hs_o,
    output logic                  vs_o
);
    // half an lsb of the output
    localparam logic signed [SUM_WIDTH-1:0] ROUND = SUM_WIDTH'(1 << (SHIFT - 1));

    logic [MUL_WIDTH-1:0]        prod_q [4];
    logic signed [SUM_WIDTH-1:0] sum_q;

    // strobes through the multiply and sum stages
    logic [1:0] valid_d;
    logic [1:0] first_pix_d;
    logic [1:0] first_row_d;

    always_ff @(posedge clk) begin
        prod_q[0] <= w0_i * taps.tap0;
        prod_q[1] <= w1_i * taps.tap1;
        prod_q[2] <= w2_i * taps.tap2;
        prod_q[3] <= w3_i * taps.tap3;

        // outer taps carry negative weights
        sum_q <= $signed({2'b00, prod_q[1]}) + $signed({2'b00, prod_q[2]})
               - $signed({2'b00, prod_q[0]}) - $signed({2'b00, prod_q[3]}) + ROUND;

        if (sum_q[SUM_WIDTH-1]) begin
            do_o <= '0;
        end else if (|sum_q[SUM_WIDTH-2:SHIFT+DATA_WIDTH]) begin
            do_o <= '1;
        end else begin
            do_o <= sum_q[SHIFT +: DATA_WIDTH];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_d     <= '0;
            first_pix_d <= '0;
            first_row_d <= '0;
            de_o        <= 1'b0;
            hs_o        <= 1'b0;
            vs_o        <= 1'b0;
        end else begin
            valid_d     <= {valid_d[0], taps.valid};
            first_pix_d <= {first_pix_d[0], taps.first_pix};
            first_row_d <= {first_row_d[0], taps.first_row};
            de_o        <= valid_d[1];
            hs_o        <= valid_d[1] & first_pix_d[1];
            vs_o        <= valid_d[1] & first_pix_d[1] & first_row_d[1];
        end
    end

endmodule

// File: logic/vscale_top.sv
`timescale 1ns/1ps

module vscale_top #(
    parameter int DATA_WIDTH = 8,
    parameter int ROW_LEN_MAX = 1024,
    parameter int TABLE_BITS = 10,
    parameter int SPARSE_GAP = 2,
    localparam int ADDR_WIDTH = $clog2(ROW_LEN_MAX),
    localparam int ROW_BITS = vscale_pkg::ROW_BITS,
    localparam int CW = vscale_pkg::COE_WIDTH
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [DATA_WIDTH-1:0] di_i,
    input  logic                  de_i,
    input  logic                  vs_i,
    // 4.12 source rows per output row
    input  logic [15:0]           scale_step_i,
    // pixels per row minus one
    input  logic [ADDR_WIDTH-1:0] row_len_i,
    output logic [DATA_WIDTH-1:0] do_o,
    output logic                  de_o,
    output logic                  hs_o,
    output logic                  vs_o
);
    logic [ROW_BITS-1:0]   rows_done;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  rd_strobe;
    logic                  first_pix;
    logic                  first_row;
    logic [ROW_BITS-1:0]   newest_row;
    logic [TABLE_BITS-1:0] phase;
    logic [CW-1:0]         w0;
    logic [CW-1:0]         w1;
    logic [CW-1:0]         w2;
    logic [CW-1:0]         w3;

    row_tap_if #(.DATA_WIDTH(DATA_WIDTH)) tap_bus ();

    row_store #(
        .DATA_WIDTH  (DATA_WIDTH),
        .ROW_LEN_MAX (ROW_LEN_MAX)
    ) row_store0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .di_i         (di_i),
        .de_i         (de_i),
        .vs_i         (vs_i),
        .rd_addr_i    (rd_addr),
        .rd_strobe_i  (rd_strobe),
        .first_pix_i  (first_pix),
        .first_row_i  (first_row),
        .newest_row_i (newest_row),
        .rows_done_o  (rows_done),
        .taps         (tap_bus.src)
    );

    row_sequencer #(
        .ROW_LEN_MAX (ROW_LEN_MAX),
        .TABLE_BITS  (TABLE_BITS),
        .SPARSE_GAP  (SPARSE_GAP)
    ) row_sequencer0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .vs_i         (vs_i),
        .scale_step_i (scale_step_i),
        .row_len_i    (row_len_i),
        .rows_done_i  (rows_done),
        .rd_addr_o    (rd_addr),
        .rd_strobe_o  (rd_strobe),
        .first_pix_o  (first_pix),
        .first_row_o  (first_row),
        .newest_row_o (newest_row),
        .phase_o      (phase)
    );

    coe_rom #(
        .TABLE_BITS (TABLE_BITS)
    ) coe_rom0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .phase_i  (phase),
        .w0_o     (w0),
        .w1_o     (w1),
        .w2_o     (w2),
        .w3_o     (w3)
    );

    tap_filter #(
        .DATA_WIDTH (DATA_WIDTH)
    ) tap_filter0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .w0_i     (w0),
        .w1_i     (w1),
        .w2_i     (w2),
        .w3_i     (w3),
        .taps     (tap_bus.dst),
        .do_o     (do_o),
        .de_o     (de_o),
        .hs_o     (hs_o),
        .vs_o     (vs_o)
    );

endmodule

// File: testbench/vscale_model.svh
`ifndef VSCALE_MODEL_SVH
`define VSCALE_MODEL_SVH

// expected output of one frame, in output order
logic [DATA_WIDTH-1:0] exp_pix [$];
logic [DATA_WIDTH-1:0] exp_unity [$];
logic                  exp_hs [$];
logic                  exp_vs [$];
int                    exp_rows;
int                    clamp_hits;

// catmull-rom weight magnitude on a scale of 512, t = phase / 2^TABLE_BITS
function automatic int kernel_weight(input int tap, input int phase);
    real t;
    real v;
    t = real'(phase) / real'(1 << TABLE_BITS);
    case (tap)
        0:       v = (t * t * t - 2.0 * t * t + t) / 2.0;
        1:       v = (3.0 * t * t * t - 5.0 * t * t + 2.0) / 2.0;
        2:       v = (-3.0 * t * t * t + 4.0 * t * t + t) / 2.0;
        default: v = (t * t - t * t * t) / 2.0;
    endcase
    // weights are never negative, so truncation after +0.5 rounds to nearest
    return $rtoi(v * 512.0 + 0.5);
endfunction

// walk the output positions of a frame held in src_pix
task automatic build_expected(input int nrows, input int npix, input int step);
    int p;
    int m;
    int ph;
    int acc;
    int w [4];
    int tp [4];
    exp_pix.delete();
    exp_unity.delete();
    exp_hs.delete();
    exp_vs.delete();
    exp_rows   = 0;
    clamp_hits = 0;
    p = 2 * vscale_pkg::ROW_ONE;
    // row m needs source row m+1 inside the frame
    while ((p / vscale_pkg::ROW_ONE) + 1 < nrows) begin
        m  = p / vscale_pkg::ROW_ONE;
        ph = (p % vscale_pkg::ROW_ONE) >> (12 - TABLE_BITS);
        for (int k = 0; k < 4; k++) begin
            w[k] = kernel_weight(k, ph);
        end
        for (int x = 0; x < npix; x++) begin
            for (int k = 0; k < 4; k++) begin
                tp[k] = int'(src_pix[m - 2 + k][x]);
            end
            acc = w[1] * tp[1] + w[2] * tp[2] - w[0] * tp[0] - w[3] * tp[3] + 256;
            acc = acc >>> 9;
            if (acc < 0) begin
                acc = 0;
                clamp_hits++;
            end else if (acc > (1 << DATA_WIDTH) - 1) begin
                acc = (1 << DATA_WIDTH) - 1;
                clamp_hits++;
            end
            exp_pix.push_back(DATA_WIDTH'(acc));
            exp_unity.push_back(src_pix[m - 1][x]);
            exp_hs.push_back(x == 0);
            exp_vs.push_back((x == 0) && (exp_rows == 0));
        end
        exp_rows++;
        p = p + step;
    end
endtask

`endif

// File: testbench/tb_vscale.sv
`timescale 1ns/1ps

module tb_vscale;

    localparam int DATA_WIDTH  = 8;
    localparam int ROW_LEN_MAX = 1024;
    localparam int TABLE_BITS  = 10;
    localparam int SPARSE_GAP  = 2;
    localparam int ADDR_WIDTH  = $clog2(ROW_LEN_MAX);
    localparam int NFRAMES     = 8;
    localparam int MAX_ROWS    = 12;
    localparam int MAX_PIX     = 32;

    logic                  clk;
    logic                  arst_n_i;
    logic [DATA_WIDTH-1:0] di_i;
    logic                  de_i;
    logic                  vs_i;
    logic [15:0]           scale_step_i;
    logic [ADDR_WIDTH-1:0] row_len_i;
    logic [DATA_WIDTH-1:0] do_o;
    logic                  de_o;
    logic                  hs_o;
    logic                  vs_o;

    integer seed = 32'h96ed;
    int     fail_count = 0;
    int     limit_cycles = 0;

    // frame shapes, drawn before the run starts
    int fr_rows [NFRAMES];
    int fr_pix [NFRAMES];
    int fr_step [NFRAMES];

    // current source frame
    logic [DATA_WIDTH-1:0] src_pix [MAX_ROWS][MAX_PIX];

    // collected from de_o
    logic [DATA_WIDTH-1:0] obs_pix [$];
    logic                  obs_hs [$];
    logic                  obs_vs [$];
    int                    obs_rows = 0;

    `include "vscale_model.svh"

    vscale_top #(
        .DATA_WIDTH  (DATA_WIDTH),
        .ROW_LEN_MAX (ROW_LEN_MAX),
        .TABLE_BITS  (TABLE_BITS),
        .SPARSE_GAP  (SPARSE_GAP)
    ) dut0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .di_i         (di_i),
        .de_i         (de_i),
        .vs_i         (vs_i),
        .scale_step_i (scale_step_i),
        .row_len_i    (row_len_i),
        .do_o         (do_o),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        fail_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_pixel(input string name, input logic [DATA_WIDTH-1:0] exp,
                               input logic [DATA_WIDTH-1:0] obs);
        if (obs !== exp) begin
            fail_count++;
            $display("[FAIL] %0t ns %s expected %0d observed %0d", $time, name, exp, obs);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic obs);
        if (obs !== exp) begin
            fail_count++;
            $display("[FAIL] %0t ns %s expected %b observed %b", $time, name, exp, obs);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int obs);
        if (obs != exp) begin
            fail_count++;
            $display("[FAIL] %0t ns %s expected %0d observed %0d", $time, name, exp, obs);
            abort_run();
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // room for every output row one source row can release
    function automatic int blank_cycles(input int npix, input int step);
        return (vscale_pkg::ROW_ONE / step + 1) * (npix * (SPARSE_GAP + 1) + 10);
    endfunction

    function automatic int frame_cycles(input int f);
        return 8 + fr_rows[f] * (fr_pix[f] + blank_cycles(fr_pix[f], fr_step[f])) + 10;
    endfunction

    // frame 1 uses row pairs 0,max,max,0 so the kernel overshoots both ways
    task automatic drive_frame(input int f);
        int bl;
        for (int r = 0; r < fr_rows[f]; r++) begin
            for (int x = 0; x < fr_pix[f]; x++) begin
                if (f == 1) begin
                    src_pix[r][x] = (((r + 1) / 2) % 2 == 1) ? '1 : '0;
                end else begin
                    src_pix[r][x] = DATA_WIDTH'(rand_range(0, (1 << DATA_WIDTH) - 1));
                end
            end
        end
        bl = blank_cycles(fr_pix[f], fr_step[f]);
        @(negedge clk);
        scale_step_i = 16'(fr_step[f]);
        row_len_i    = ADDR_WIDTH'(fr_pix[f] - 1);
        vs_i         = 1'b1;
        de_i         = 1'b0;
        repeat (3) @(negedge clk);
        vs_i = 1'b0;
        repeat (4) @(negedge clk);
        for (int r = 0; r < fr_rows[f]; r++) begin
            for (int x = 0; x < fr_pix[f]; x++) begin
                di_i = src_pix[r][x];
                de_i = 1'b1;
                @(negedge clk);
            end
            de_i = 1'b0;
            di_i = '0;
            repeat (bl) @(negedge clk);
        end
        repeat (10) @(negedge clk);
    endtask

    task automatic compare_frame(input int f);
        check_count($sformatf("output rows frame %0d", f), exp_rows, obs_rows);
        check_count($sformatf("output pixels frame %0d", f), exp_pix.size(), obs_pix.size());
        for (int i = 0; i < exp_pix.size(); i++) begin
            check_pixel($sformatf("do_o frame %0d pixel %0d", f, i), exp_pix[i], obs_pix[i]);
            if (fr_step[f] == vscale_pkg::ROW_ONE) begin
                check_pixel($sformatf("do_o unity frame %0d pixel %0d", f, i),
                            exp_unity[i], obs_pix[i]);
            end
            check_flag($sformatf("hs_o frame %0d pixel %0d", f, i), exp_hs[i], obs_hs[i]);
            check_flag($sformatf("vs_o frame %0d pixel %0d", f, i), exp_vs[i], obs_vs[i]);
        end
        if (f == 1) begin
            check_flag("clamp exercised", 1'b1, clamp_hits > 0);
        end
        obs_pix.delete();
        obs_hs.delete();
        obs_vs.delete();
        obs_rows = 0;
    endtask

    // sample 10 ns after the rising edge, well clear of the input changes
    initial begin : monitor
        int cyc;
        int last_cyc;
        bit have_prev;
        cyc       = 0;
        last_cyc  = 0;
        have_prev = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            cyc++;
            if (de_o) begin
                if (vs_i) begin
                    report_error("de_o is high while vs_i holds the frame in reset");
                end
                obs_pix.push_back(do_o);
                obs_hs.push_back(hs_o);
                obs_vs.push_back(vs_o);
                if (hs_o) begin
                    obs_rows++;
                end else if (have_prev) begin
                    check_count("de_o spacing", SPARSE_GAP + 1, cyc - last_cyc);
                end
                have_prev = 1'b1;
                last_cyc  = cyc;
            end
        end
    end

    initial begin : watchdog
        vscale_pkg::seq_state_e st;
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        st = dut0.row_sequencer0.state_q;
        $display("ERROR: run did not finish within %0d cycles, sequencer state %s",
                 limit_cycles, st.name());
        abort_run();
    end

    initial begin : stimulus
        int total;
        arst_n_i     = 1'b0;
        di_i         = '0;
        de_i         = 1'b0;
        vs_i         = 1'b1;
        scale_step_i = 16'(vscale_pkg::ROW_ONE);
        row_len_i    = '0;
        total        = 20;
        for (int f = 0; f < NFRAMES; f++) begin
            fr_rows[f] = rand_range(6, MAX_ROWS);
            fr_pix[f]  = rand_range(8, MAX_PIX);
            if (f == 0) begin
                fr_step[f] = vscale_pkg::ROW_ONE;
            end else if (f == 1) begin
                // phase of row 1 lands where overshoot is large
                fr_step[f] = rand_range(2560, 3584);
            end else begin
                fr_step[f] = rand_range(2048, 8192);
            end
            total += frame_cycles(f);
        end
        limit_cycles = total * (SPARSE_GAP + 1) * 4;

        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        repeat (5) @(negedge clk);

        for (int f = 0; f < NFRAMES; f++) begin
            drive_frame(f);
            build_expected(fr_rows[f], fr_pix[f], fr_step[f]);
            compare_frame(f);
        end

        if (fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// File: vlog.f
+incdir+testbench
common/vscale_pkg.sv
common/row_tap_if.sv
row_store/row_ram.sv
row_store/row_store.sv
logic/row_sequencer.sv
logic/coe_rom.sv
logic/tap_filter.sv
logic/vscale_top.sv
testbench/tb_vscale.sv
